// File: common/panel_pkg.sv
package panel_pkg;

    // One data byte on the shared backplane bus
    typedef logic [7:0] board_byte_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        READ,
        WRITE
    } bus_state_t;

    // Enable bit 0 strobes a board read, bit 1 strobes a board write
    typedef struct packed {
        logic [3:0]  address;
        logic [1:0]  enable_n;
        board_byte_t data_out;
        logic        data_oe;
    } backplane_t;

    typedef struct packed {
        logic [3:0] digit_select; // One-hot, bit 0 is the rightmost digit
        logic [6:0] segments;     // Bit 0 is segment a, bit 6 is segment g
    } display_t;

    function automatic logic [6:0] seg_decode(input logic [3:0] nibble);
        logic [6:0] seg;
        case (nibble)
            4'h0: seg = 7'h3f;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5b;
            4'h3: seg = 7'h4f;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6d;
            4'h6: seg = 7'h7d;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7f;
            4'h9: seg = 7'h6f;
            4'ha: seg = 7'h77;
            4'hb: seg = 7'h7c; // Lower case b so it differs from 8
            4'hc: seg = 7'h39;
            4'hd: seg = 7'h5e; // Lower case d so it differs from 0
            4'he: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return seg;
    endfunction

endpackage

// File: common/wb_pkg.sv
package wb_pkg;

    // Host to register port, classic single cycles only
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // Register groups after the address has been decoded
    typedef enum logic [1:0] {
        SEL_INPUT,
        SEL_OUTPUT,
        SEL_DISPLAY,
        SEL_NONE
    } reg_sel_t;

    // Word addresses of the register map
    localparam logic [5:0] ADR_INPUT_BASE  = 6'd0;  // Filtered inputs of boards 0 to 15
    localparam logic [5:0] ADR_OUTPUT_BASE = 6'd16; // Output bytes of boards 0 to 15
    localparam logic [5:0] ADR_DISPLAY     = 6'd32;

endpackage

// File: io_bus/io_bus_sequencer.sv
`timescale 1ns/1ps

module io_bus_sequencer #(
    parameter int BOARDS           = 16,
    parameter int INSTALLED_BOARDS = 2
) (
    input  logic                   Clock_10ms,
    input  logic                   Rst_n,
    input  panel_pkg::board_byte_t data_in,
    input  panel_pkg::board_byte_t out_bytes [BOARDS],
    output panel_pkg::backplane_t  backplane,
    output panel_pkg::board_byte_t sample,
    output logic [BOARDS-1:0]      sample_valid
);
    import panel_pkg::*;

    localparam int CNT_W = (BOARDS > 1) ? $clog2(BOARDS) : 1;
    localparam logic [CNT_W-1:0] LAST_BOARD = CNT_W'(INSTALLED_BOARDS - 1);

    bus_state_t       state;
    bus_state_t       state_next;
    logic [CNT_W-1:0] board_cnt;

    always_comb begin
        case (state)
            IDLE:    state_next = ADDR;
            ADDR:    state_next = READ;
            READ:    state_next = WRITE;
            default: state_next = ADDR; // WRITE hands over to the next board
        endcase
    end

    always_ff @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            state     <= IDLE;
            board_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == WRITE) begin
                board_cnt <= (board_cnt == LAST_BOARD) ? '0 : board_cnt + 1'b1;
            end
        end
    end

    // The read strobe is released on this edge, so the board still drives data_in
    always_ff @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            sample <= '0;
        end else if (state == READ) begin
            sample <= data_in;
        end
    end

    always_ff @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            sample_valid <= '0;
        end else begin
            sample_valid <= '0;
            if (state == READ) begin
                sample_valid[board_cnt] <= 1'b1;
            end
        end
    end

    always_comb begin
        backplane.address  = 4'(board_cnt);
        backplane.enable_n = 2'b11;
        backplane.data_out = '0;
        backplane.data_oe  = 1'b0;
        case (state)
            READ: begin
                backplane.enable_n[0] = 1'b0;
            end
            WRITE: begin
                backplane.enable_n[1] = 1'b0;
                backplane.data_oe     = 1'b1;
                backplane.data_out    = out_bytes[board_cnt];
            end
            default: begin
                backplane.enable_n = 2'b11; // Address settles with both strobes idle
            end
        endcase
    end

endmodule

// File: io_bus/io_board_slot.sv
`timescale 1ns/1ps

module io_board_slot (
    input  logic                   Clock_10ms,
    input  logic                   Rst_n,
    input  panel_pkg::board_byte_t sample,
    input  logic                   sample_valid,
    input  logic                   wr_en,
    input  panel_pkg::board_byte_t wr_byte,
    output panel_pkg::board_byte_t filtered,
    output panel_pkg::board_byte_t out_byte
);
    import panel_pkg::*;

    board_byte_t prev_sample;

    // A value has to be read on two sweeps in a row before the host sees it
    always_ff @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            prev_sample <= '0;
            filtered    <= '0;
        end else if (sample_valid) begin
            prev_sample <= sample;
            if (sample == prev_sample) begin
                filtered <= sample;
            end
        end
    end

    always_ff @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            out_byte <= '0;
        end else if (wr_en) begin
            out_byte <= wr_byte; // Goes out on the board's next WRITE phase
        end
    end

endmodule

// File: display/display_scanner.sv
`timescale 1ns/1ps

module display_scanner (
    input  logic                Clock_10ms,
    input  logic                Rst_n,
    input  logic [15:0]         display_value,
    output panel_pkg::display_t display
);
    import panel_pkg::*;

    logic [3:0] digit_ring;
    logic [1:0] digit_idx;
    logic [3:0] nibble;

    // Ring and index advance together, so ring bit n is lit while the index is n
    always_ff @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            digit_ring <= 4'b0001;
            digit_idx  <= 2'd0;
        end else begin
            digit_ring <= {digit_ring[2:0], digit_ring[3]};
            digit_idx  <= digit_idx + 2'd1;
        end
    end

    assign nibble = display_value[digit_idx*4 +: 4];

    assign display.digit_select = digit_ring;
    assign display.segments     = seg_decode(nibble); // Same cycle as the select

endmodule

// File: source/wb_register_port.sv
`timescale 1ns/1ps

module wb_register_port #(
    parameter int BOARDS           = 16,
    parameter int INSTALLED_BOARDS = 2
) (
    input  logic                   Clock_10ms,
    input  logic                   Rst_n,
    input  wb_pkg::wb_req_t        wb_req,
    output wb_pkg::wb_rsp_t        wb_rsp,
    input  panel_pkg::board_byte_t filtered [BOARDS],
    input  panel_pkg::board_byte_t out_bytes [BOARDS],
    output logic [BOARDS-1:0]      wr_en,
    output panel_pkg::board_byte_t wr_byte,
    output logic [15:0]            display_value
);
    import wb_pkg::*;
    import panel_pkg::*;

    logic        ack_q;
    logic [15:0] rd_dat_q;
    logic        req_hit;
    logic [3:0]  board_idx;
    logic        board_ok;
    board_byte_t in_byte;
    board_byte_t out_byte;
    reg_sel_t    sel;
    logic [15:0] rd_dat;

    // A held strobe is served once, the ack itself blocks the second hit
    assign req_hit   = wb_req.cyc & wb_req.stb & ~ack_q;
    assign board_idx = wb_req.adr[3:0];

    // Only installed boards are reachable, all other slots read as 0
    always_comb begin
        board_ok = 1'b0;
        in_byte  = '0;
        out_byte = '0;
        for (int i = 0; i < INSTALLED_BOARDS; i++) begin
            if (board_idx == 4'(i)) begin
                board_ok = 1'b1;
                in_byte  = filtered[i];
                out_byte = out_bytes[i];
            end
        end
    end

    always_comb begin
        if (wb_req.adr == ADR_DISPLAY) begin
            sel = SEL_DISPLAY;
        end else if (!board_ok) begin
            sel = SEL_NONE;
        end else if (wb_req.adr[5:4] == ADR_INPUT_BASE[5:4]) begin
            sel = SEL_INPUT;
        end else if (wb_req.adr[5:4] == ADR_OUTPUT_BASE[5:4]) begin
            sel = SEL_OUTPUT;
        end else begin
            sel = SEL_NONE;
        end
    end

    always_comb begin
        case (sel)
            SEL_INPUT:   rd_dat = {8'h00, in_byte};
            SEL_OUTPUT:  rd_dat = {8'h00, out_byte};
            SEL_DISPLAY: rd_dat = display_value;
            default:     rd_dat = '0;
        endcase
    end

    // Slots load on the edge that raises ack
    always_comb begin
        wr_en = '0;
        if (req_hit && wb_req.we && sel == SEL_OUTPUT) begin
            wr_en[board_idx] = 1'b1;
        end
    end

    assign wr_byte = wb_req.dat[7:0];

    always_ff @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            ack_q         <= 1'b0;
            rd_dat_q      <= '0;
            display_value <= '0;
        end else begin
            ack_q <= req_hit;
            if (req_hit) begin
                rd_dat_q <= rd_dat;
            end
            if (req_hit && wb_req.we && sel == SEL_DISPLAY) begin
                display_value <= wb_req.dat;
            end
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};

endmodule

// File: source/panel_io_top.sv
`timescale 1ns/1ps

module panel_io_top #(
    parameter int BOARDS           = 16,
    parameter int INSTALLED_BOARDS = 2
) (
    input  logic                   Clock_10ms,
    input  logic                   Rst_n,
    input  wb_pkg::wb_req_t        wb_req,
    output wb_pkg::wb_rsp_t        wb_rsp,
    input  panel_pkg::board_byte_t data_in,
    output panel_pkg::backplane_t  backplane,
    output panel_pkg::display_t    display
);
    import panel_pkg::*;

    board_byte_t       out_bytes [BOARDS];
    board_byte_t       filtered [BOARDS];
    board_byte_t       sample;
    logic [BOARDS-1:0] sample_valid;
    logic [BOARDS-1:0] wr_en;
    board_byte_t       wr_byte;
    logic [15:0]       display_value;

    io_bus_sequencer #(
        .BOARDS           (BOARDS),
        .INSTALLED_BOARDS (INSTALLED_BOARDS)
    ) i_io_bus_sequencer (
        .Clock_10ms   (Clock_10ms),
        .Rst_n        (Rst_n),
        .data_in      (data_in),
        .out_bytes    (out_bytes),
        .backplane    (backplane),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    // Every slot exists, the sequencer and the port only touch installed ones
    for (genvar b = 0; b < BOARDS; b++) begin : g_slot
        io_board_slot i_io_board_slot (
            .Clock_10ms   (Clock_10ms),
            .Rst_n        (Rst_n),
            .sample       (sample),
            .sample_valid (sample_valid[b]),
            .wr_en        (wr_en[b]),
            .wr_byte      (wr_byte),
            .filtered     (filtered[b]),
            .out_byte     (out_bytes[b])
        );
    end

    wb_register_port #(
        .BOARDS           (BOARDS),
        .INSTALLED_BOARDS (INSTALLED_BOARDS)
    ) i_wb_register_port (
        .Clock_10ms    (Clock_10ms),
        .Rst_n         (Rst_n),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .filtered      (filtered),
        .out_bytes     (out_bytes),
        .wr_en         (wr_en),
        .wr_byte       (wr_byte),
        .display_value (display_value)
    );

    display_scanner i_display_scanner (
        .Clock_10ms    (Clock_10ms),
        .Rst_n         (Rst_n),
        .display_value (display_value),
        .display       (display)
    );

endmodule

// File: verif/panel_io_tb_tasks.svh
// Prints the fail message and ends the run
task automatic stop_on_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first failure");
endtask

task automatic report_mismatch(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    stop_on_failure();
endtask

task automatic report_timeout(input string what, input int cycles);
    $display("Timed out after %0d cycles while waiting for %s", cycles, what);
    stop_on_failure();
endtask

task automatic check_byte(input board_byte_t actual, input board_byte_t expected,
                          input string what);
    if (actual !== expected) begin
        report_mismatch($sformatf("%s: got %02h, expected %02h", what, actual, expected));
    end
endtask

task automatic check_rsp(input wb_rsp_t actual, input wb_rsp_t expected, input string what);
    if (actual !== expected) begin
        report_mismatch($sformatf("%s: got ack %0b dat %04h, expected ack %0b dat %04h",
                                  what, actual.ack, actual.dat, expected.ack, expected.dat));
    end
endtask

task automatic check_display(input display_t actual, input display_t expected,
                             input string what);
    if (actual !== expected) begin
        report_mismatch($sformatf("%s: got select %04b seg %02h, expected select %04b seg %02h",
            what, actual.digit_select, actual.segments,
            expected.digit_select, expected.segments));
    end
endtask

task automatic check_backplane(input backplane_t actual, input backplane_t expected,
                               input string what);
    if (actual !== expected) begin
        report_mismatch($sformatf("%s: got adr %0d en_n %02b out %02h oe %0b, expected %0d %02b %02h %0b",
            what, actual.address, actual.enable_n, actual.data_out, actual.data_oe,
            expected.address, expected.enable_n, expected.data_out, expected.data_oe));
    end
endtask

// Returns at a falling edge inside the given phase of one board
task automatic wait_phase(input int board, input bus_state_t phase);
    backplane_t exp;
    int         cycles;
    exp    = expected_backplane(board, phase);
    cycles = 0;
    @(negedge Clock_10ms);
    while (backplane.address != exp.address || backplane.enable_n != exp.enable_n) begin
        cycles++;
        if (cycles > PHASE_TIMEOUT) begin
            report_timeout($sformatf("phase %s of board %0d", phase.name(), board), cycles);
        end
        @(negedge Clock_10ms);
    end
    check_backplane(backplane, exp, $sformatf("%s phase of board %0d", phase.name(), board));
endtask

// One classic cycle; ack must come exactly one cycle after the request
task automatic wb_access(input logic we, input logic [5:0] adr, input logic [15:0] dat,
                         output wb_rsp_t rsp);
    wb_rsp_t after;
    wb_rsp_t idle;
    int      cycles;
    cycles = 0;
    idle   = '0;
    @(posedge Clock_10ms);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge Clock_10ms);
    while (!wb_rsp.ack) begin
        cycles++;
        if (cycles > ACK_TIMEOUT) begin
            report_timeout($sformatf("the ack of address %0d", adr), cycles);
        end
        @(negedge Clock_10ms);
    end
    if (cycles != 1) begin
        report_mismatch($sformatf("ack of address %0d after %0d cycles, expected 1", adr, cycles));
    end
    rsp = wb_rsp;
    @(posedge Clock_10ms);
    #1;
    wb_req = '0;
    @(negedge Clock_10ms);
    after     = wb_rsp;
    after.dat = '0; // Only the ack matters once the cycle is over
    check_rsp(after, idle, $sformatf("ack after the access to address %0d", adr));
endtask

task automatic wb_read(input logic [5:0] adr, output logic [15:0] dat);
    wb_rsp_t rsp;
    wb_rsp_t exp;
    wb_access(1'b0, adr, 16'h0000, rsp);
    exp.ack = 1'b1;
    exp.dat = expected_read(adr);
    check_rsp(rsp, exp, $sformatf("read of address %0d", adr));
    dat = rsp.dat;
endtask

task automatic wb_write(input logic [5:0] adr, input logic [15:0] dat);
    wb_rsp_t rsp;
    wb_rsp_t exp;
    wb_access(1'b1, adr, dat, rsp);
    rsp.dat = '0;
    exp.ack = 1'b1;
    exp.dat = '0;
    check_rsp(rsp, exp, $sformatf("write to address %0d", adr));
    model_write(adr, dat);
endtask

// File: verif/panel_io_tb.sv
`timescale 1ns/1ps

module panel_io_tb;
    import panel_pkg::*;
    import wb_pkg::*;

    localparam int BOARDS           = 16;
    localparam int INSTALLED_BOARDS = 2;
    localparam int SWEEP_CYCLES     = 3 * INSTALLED_BOARDS;
    localparam int SETTLE_CYCLES    = 2 * SWEEP_CYCLES + 2; // Longest time until a held input is readable
    localparam int ACK_TIMEOUT      = 8;
    localparam int PHASE_TIMEOUT    = 3 * BOARDS + 4;

    logic        Clock_10ms;
    logic        Rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    board_byte_t data_in;
    backplane_t  backplane;
    display_t    display;

    board_byte_t board_in [BOARDS];  // What each board presents on a read
    board_byte_t model_in [BOARDS];  // Expected filtered inputs
    board_byte_t model_out [BOARDS];
    logic [15:0] model_display;
    logic [3:0]  model_select;
    logic        display_check_on;
    int          seed;

    panel_io_top #(
        .BOARDS           (BOARDS),
        .INSTALLED_BOARDS (INSTALLED_BOARDS)
    ) i_panel_io_top (
        .Clock_10ms (Clock_10ms),
        .Rst_n      (Rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .data_in    (data_in),
        .backplane  (backplane),
        .display    (display)
    );

    initial Clock_10ms = 1'b0;
    always #4 Clock_10ms = ~Clock_10ms;

    // The addressed board drives the bus only while its read strobe is low
    assign data_in = (backplane.enable_n[0] == 1'b0) ? board_in[backplane.address] : 8'h00;

    // Digit 0 is lit after reset and the scan moves one digit per cycle
    always @(posedge Clock_10ms or negedge Rst_n) begin
        if (!Rst_n) begin
            model_select <= 4'b0001;
        end else begin
            model_select <= {model_select[2:0], model_select[3]};
        end
    end

    function automatic logic [15:0] expected_read(input logic [5:0] adr);
        logic [15:0] value;
        logic        installed;
        value     = '0;
        installed = int'(adr[3:0]) < INSTALLED_BOARDS;
        if (adr == ADR_DISPLAY) begin
            value = model_display;
        end else if (adr[5:4] == ADR_INPUT_BASE[5:4] && installed) begin
            value = {8'h00, model_in[adr[3:0]]};
        end else if (adr[5:4] == ADR_OUTPUT_BASE[5:4] && installed) begin
            value = {8'h00, model_out[adr[3:0]]};
        end
        return value;
    endfunction

    function automatic void model_write(input logic [5:0] adr, input logic [15:0] dat);
        if (adr == ADR_DISPLAY) begin
            model_display = dat;
        end else if (adr[5:4] == ADR_OUTPUT_BASE[5:4] && int'(adr[3:0]) < INSTALLED_BOARDS) begin
            model_out[adr[3:0]] = dat[7:0];
        end
    endfunction

    function automatic backplane_t expected_backplane(input int board, input bus_state_t phase);
        backplane_t bp;
        bp.address  = 4'(board);
        bp.enable_n = 2'b11;
        bp.data_out = '0;
        bp.data_oe  = 1'b0;
        if (phase == READ) begin
            bp.enable_n = 2'b10;
        end else if (phase == WRITE) begin
            bp.enable_n = 2'b01;
            bp.data_oe  = 1'b1;
            bp.data_out = model_out[4'(board)];
        end
        return bp;
    endfunction

    function automatic display_t expected_display(input logic [15:0] value, input logic [3:0] select);
        display_t   d;
        logic [3:0] nibble;
        case (select)
            4'b0010: nibble = value[7:4];
            4'b0100: nibble = value[11:8];
            4'b1000: nibble = value[15:12];
            default: nibble = value[3:0];
        endcase
        d.digit_select = select;
        d.segments     = seg_decode(nibble);
        return d;
    endfunction

    `include "panel_io_tb_tasks.svh"

    always @(negedge Clock_10ms) begin
        if (display_check_on) begin
            check_display(display, expected_display(model_display, model_select), "display scan");
        end
    end

    initial begin : stimulus
        logic [15:0] rd;
        logic [15:0] value;
        board_byte_t held;
        board_byte_t bounce;
        wb_rsp_t     rsp_idle;
        int          b;
        int          s;
        int          k;
        seed             = 32'h8990ccad;
        Rst_n            = 1'b0;
        wb_req           = '0;
        rsp_idle         = '0;
        model_display    = '0;
        display_check_on = 1'b0;
        for (b = 0; b < BOARDS; b++) begin
            board_in[b]  = '0;
            model_in[b]  = '0;
            model_out[b] = '0;
        end

        repeat (9) @(posedge Clock_10ms);
        @(negedge Clock_10ms);
        check_backplane(backplane, expected_backplane(0, IDLE), "backplane in reset");
        check_rsp(wb_rsp, rsp_idle, "Wishbone response in reset");
        check_display(display, expected_display(16'h0000, 4'b0001), "display in reset");
        @(posedge Clock_10ms);
        #1;
        Rst_n = 1'b1;

        // Two full sweeps in strict ADDR, READ, WRITE order over the installed boards
        repeat (4) @(posedge Clock_10ms);
        wait_phase(0, ADDR);
        for (s = 0; s < 2; s++) begin
            for (b = 0; b < INSTALLED_BOARDS; b++) begin
                check_backplane(backplane, expected_backplane(b, ADDR), "sweep in ADDR");
                @(negedge Clock_10ms);
                check_backplane(backplane, expected_backplane(b, READ), "sweep in READ");
                @(negedge Clock_10ms);
                check_backplane(backplane, expected_backplane(b, WRITE), "sweep in WRITE");
                @(negedge Clock_10ms);
            end
        end

        for (b = 0; b < INSTALLED_BOARDS; b++) begin
            @(posedge Clock_10ms);
            #1;
            held               = 8'($random(seed));
            board_in[4'(b)]    = held;
            repeat (SETTLE_CYCLES) @(posedge Clock_10ms);
            model_in[4'(b)]    = held;
            wb_read(ADR_INPUT_BASE + 6'(b), rd);
            check_byte(rd[7:0], held, "held input byte");

            bounce = held;
            for (k = 0; k < 6; k++) begin
                wait_phase(b, READ);
                @(posedge Clock_10ms);
                #1;
                bounce          = bounce ^ (8'($random(seed)) | 8'h01); // Bit 0 always flips
                board_in[4'(b)] = bounce;
            end
            wb_read(ADR_INPUT_BASE + 6'(b), rd);
            check_byte(rd[7:0], held, "input changed on every sweep");

            repeat (SETTLE_CYCLES) @(posedge Clock_10ms);
            model_in[4'(b)] = bounce;
            wb_read(ADR_INPUT_BASE + 6'(b), rd);
            check_byte(rd[7:0], bounce, "input after it settled");
        end

        for (b = 0; b < INSTALLED_BOARDS; b++) begin
            wb_write(ADR_OUTPUT_BASE + 6'(b), {8'h00, 8'($random(seed))});
            wait_phase(b, WRITE);
            wb_read(ADR_OUTPUT_BASE + 6'(b), rd);
            check_byte(rd[7:0], model_out[4'(b)], "output byte read back");
        end

        // Boards that are not installed and unmapped addresses
        wb_write(ADR_OUTPUT_BASE + 6'(INSTALLED_BOARDS + 3), 16'($random(seed)));
        wb_read(ADR_OUTPUT_BASE + 6'(INSTALLED_BOARDS + 3), rd);
        wb_read(ADR_INPUT_BASE + 6'(INSTALLED_BOARDS + 3), rd);
        wb_write(6'd40, 16'($random(seed)));
        wb_read(6'd40, rd);
        wb_read(6'd33, rd);
        wb_read(6'd63, rd);

        for (k = 0; k < 2; k++) begin
            value = 16'($random(seed));
            wb_write(ADR_DISPLAY, value);
            @(posedge Clock_10ms);
            #1;
            display_check_on = 1'b1;
            repeat (12) @(posedge Clock_10ms);
            #1;
            display_check_on = 1'b0;
            wb_read(ADR_DISPLAY, rd);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verif
common/panel_pkg.sv
common/wb_pkg.sv
io_bus/io_bus_sequencer.sv
io_bus/io_board_slot.sv
display/display_scanner.sv
source/wb_register_port.sv
source/panel_io_top.sv
verif/panel_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the panel I/O testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing \
    -f verilog.f \
    --top-module panel_io_tb \
    --Mdir "$BUILD_DIR" \
    -o panel_io_sim

./"$BUILD_DIR"/panel_io_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Result: pass"
else
    echo "Result: fail, see $LOG"
    exit 1
fi
